// ==== source/ddr3_pkg.sv ====
//====================================================================
// Command codes, slot and lane types and mode register words shared
// by the DDR3 command path. Compile before all other RTL files.
//====================================================================
package ddr3_pkg;

    localparam int SERDES = 16;     // Read round trip through OSER8/IDES8, in nCK

    // RAS# CAS# WE#
    typedef enum logic [2:0] {
        CMD_MRS  = 3'b000,
        CMD_REF  = 3'b001,
        CMD_PRE  = 3'b010,
        CMD_ACT  = 3'b011,
        CMD_WR   = 3'b100,
        CMD_RD   = 3'b101,
        CMD_ZQCL = 3'b110,
        CMD_NOP  = 3'b111
    } ddr3_cmd_e;

    // One memory clock on the command bus
    typedef struct packed {
        ddr3_cmd_e   cmd;
        logic [2:0]  bank;
        logic [12:0] addr;
    } cmd_slot_t;

    typedef cmd_slot_t [3:0] cmd_bundle_t;     // Slot 0 goes out first

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_REFRESH
    } op_kind_e;

    typedef struct packed {
        op_kind_e    op;
        logic [2:0]  bank;
        logic [12:0] row;
        logic [9:0]  col;
        logic [1:0]  wib;       // Word inside the BC4 burst
        logic [15:0] din;
    } mem_req_t;

    // One pclk of write lanes, phase 0 first
    typedef struct packed {
        logic [0:7][15:0] dq;
        logic [0:3]       dq_oen;   // Active low, per phase pair
        logic [0:7]       dqs;
        logic [0:3]       dqs_oen;
        logic [0:7]       dm;       // 1 masks the phase
    } wr_lanes_t;

    // Mode register fields, DDR3-800
    localparam logic [1:0] M_BL      = 2'b01;      // BC4 or BL8 on the fly
    localparam logic [3:0] M_CAS     = 4'b0100;    // CL 6
    localparam logic [2:0] M_CWL     = 3'b000;     // CWL 5
    localparam logic [2:0] M_WR      = 3'b010;     // Write recovery 6
    localparam logic       M_DLL_RST = 1'b1;
    localparam logic [2:0] M_RTT_NOM = 3'b000;     // Off, single rank
    localparam logic [1:0] M_RTT_WR  = 2'b01;      // 60 ohm, dynamic ODT
    localparam logic [1:0] M_DRIVE   = 2'b00;      // Low drive strength
    localparam logic [1:0] M_AL      = 2'b00;

    // {BA[2:0], A[12:0]}
    localparam logic [15:0] MR0_VAL =
        {3'b000, 1'b0, M_WR, M_DLL_RST, 1'b0, M_CAS[3:1], 1'b0, M_CAS[0], M_BL};
    localparam logic [15:0] MR1_VAL =
        {3'b001, 3'b000, M_RTT_NOM[2], 2'b00, M_RTT_NOM[1], M_DRIVE[1], M_AL,
         M_RTT_NOM[0], M_DRIVE[0], 1'b0};
    localparam logic [15:0] MR2_VAL = {3'b010, 2'b00, M_RTT_WR, 3'b000, M_CWL, 3'b000};
    localparam logic [15:0] MR3_VAL = {3'b011, 13'd0};

    localparam cmd_slot_t SLOT_IDLE = '{cmd: CMD_NOP, bank: 3'd0, addr: 13'd0};

endpackage

// ==== source/ddr3_request_decode.sv ====
//====================================================================
// Host request capture: picks rd/wr/refresh by priority and splits
// the word address into bank, row, column and word-in-burst.
//====================================================================
module ddr3_request_decode #(
    parameter int ROW_WIDTH  = 13,
    parameter int COL_WIDTH  = 10,
    parameter int BANK_WIDTH = 3
) (
    input  logic                                      pclk,
    input  logic                                      rst_lock_n,
    input  logic                                      rd,
    input  logic                                      wr,
    input  logic                                      refresh,
    input  logic [BANK_WIDTH+ROW_WIDTH+COL_WIDTH-1:0] addr,
    input  logic [15:0]                               din,
    input  logic                                      seq_busy,
    output ddr3_pkg::mem_req_t                        req,
    output logic                                      req_valid
);
    localparam int BANK_LSB = ROW_WIDTH + COL_WIDTH;

    logic accept;

    // Hold off one cycle after a take, seq_busy lags by a cycle
    assign accept = (rd | wr | refresh) & ~seq_busy & ~req_valid;

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;    // One-cycle pulse
        end
    end

    always_ff @(posedge pclk) begin
        if (accept) begin
            if (rd) begin
                req.op <= ddr3_pkg::OP_READ;      // Read beats write
            end else if (wr) begin
                req.op <= ddr3_pkg::OP_WRITE;
            end else begin
                req.op <= ddr3_pkg::OP_REFRESH;
            end
            req.bank <= 3'(addr[BANK_LSB+BANK_WIDTH-1:BANK_LSB]);
            req.row  <= 13'(addr[BANK_LSB-1:COL_WIDTH]);
            req.col  <= 10'(addr[COL_WIDTH-1:0]);
            req.wib  <= addr[1:0];                // Low bits pick the BC4 word
            req.din  <= din;
        end
    end

endmodule

// ==== source/ddr3_init_seq.sv ====
//====================================================================
// DDR3 power-up: reset and CKE waits, MR2/MR3/MR1/MR0 writes and a
// long ZQ calibration. init_done releases the op sequencer.
//====================================================================
module ddr3_init_seq #(
    parameter int RESET_WAIT = 20000,
    parameter int CKE_WAIT   = 50000,
    parameter int ZQ_WAIT    = 514,
    parameter int MRD        = 8,
    parameter int MOD        = 12
) (
    input  logic                  pclk,
    input  logic                  rst_lock_n,
    output ddr3_pkg::cmd_bundle_t slots,
    output logic                  ddr_reset_n,
    output logic                  cke,
    output logic                  init_done
);
    localparam int ZQ_STEP = MRD*3/4 + MOD/4 + 1;  // tMOD after MR0

    typedef enum logic [2:0] {
        S_RST_WAIT,
        S_CKE_WAIT,
        S_CONFIG,
        S_ZQ,
        S_DONE
    } init_state_e;

    init_state_e state;
    logic [16:0] timer;     // Counts down, tick at zero
    logic [4:0]  step;      // Config step, saturates at 31
    logic        tick;

    assign tick = (timer == '0);

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            state       <= S_RST_WAIT;
            timer       <= 17'(RESET_WAIT - 1);
            step        <= '0;
            ddr_reset_n <= 1'b0;
            cke         <= 1'b0;
            init_done   <= 1'b0;
        end else begin
            timer <= tick ? timer : timer - 17'd1;
            step  <= (step == '1) ? step : step + 5'd1;
            case (state)
                S_RST_WAIT: if (tick) begin
                    ddr_reset_n <= 1'b1;                // Release the reset pin
                    timer       <= 17'(CKE_WAIT - 1);
                    state       <= S_CKE_WAIT;
                end
                S_CKE_WAIT: if (tick) begin
                    cke   <= 1'b1;
                    step  <= '0;                        // Config step 0 next cycle
                    state <= S_CONFIG;
                end
                S_CONFIG: if (step == 5'(ZQ_STEP)) begin
                    timer <= 17'(ZQ_WAIT - 1);          // tZQinit
                    state <= S_ZQ;
                end
                S_ZQ: if (tick) begin
                    init_done <= 1'b1;
                    state     <= S_DONE;
                end
                default: ;                              // Done, hold
            endcase
        end
    end

    // MRS and ZQCL always go in slot 0
    always_comb begin
        slots = '{default: ddr3_pkg::SLOT_IDLE};
        if (state == S_CONFIG) begin
            case (step)
                5'(0):       slots[0] = {ddr3_pkg::CMD_MRS, ddr3_pkg::MR2_VAL};
                5'(MRD/4):   slots[0] = {ddr3_pkg::CMD_MRS, ddr3_pkg::MR3_VAL};
                5'(MRD/2):   slots[0] = {ddr3_pkg::CMD_MRS, ddr3_pkg::MR1_VAL};
                5'(MRD*3/4): slots[0] = {ddr3_pkg::CMD_MRS, ddr3_pkg::MR0_VAL};
                5'(ZQ_STEP): slots[0] = {ddr3_pkg::CMD_ZQCL, 3'd0, 13'h0400}; // A10 long cal
                default: ;
            endcase
        end
    end

endmodule

// ==== source/ddr3_op_sequencer.sv ====
//====================================================================
// Read, write and refresh sequencing. Each op runs a step count from
// its ACT or REF and places commands by the RCD slot rule.
//====================================================================
module ddr3_op_sequencer #(
    parameter int RCD = 6,
    parameter int CAS = 6,
    parameter int CWL = 5,
    parameter int RC  = 20
) (
    input  logic                  pclk,
    input  logic                  rst_lock_n,
    input  logic                  init_done,
    input  ddr3_pkg::mem_req_t    req,
    input  logic                  req_valid,
    output ddr3_pkg::cmd_bundle_t slots,
    output logic [1:0]            wr_beat,
    output logic                  rd_strobe,
    output logic                  seq_busy,
    output ddr3_pkg::mem_req_t    cur_req
);
    localparam int CMD_STEP = RCD / 4;                              // RD/WR after tRCD
    localparam int CMD_SLOT = RCD % 4;
    localparam int RD_DATA  = (RCD + CAS + ddr3_pkg::SERDES)/4 + 1; // Read data back
    localparam int WR_BEAT1 = (RCD + CWL) / 4;                      // First DQ beat

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_REFRESH
    } op_state_e;

    op_state_e  state;
    logic [4:0] step;
    logic       last;       // Final busy step of the op

    always_comb begin
        case (state)
            ST_READ:    last = (step == 5'(RD_DATA));
            ST_WRITE:   last = (step == 5'(WR_BEAT1 + 2));  // One gap after beat 2
            ST_REFRESH: last = (step == 5'(RC/4 - 1));      // tRC
            default:    last = 1'b0;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            state <= ST_IDLE;
            step  <= '0;
        end else if (state == ST_IDLE) begin
            step <= '0;
            if (req_valid && init_done) begin
                case (req.op)
                    ddr3_pkg::OP_READ:  state <= ST_READ;
                    ddr3_pkg::OP_WRITE: state <= ST_WRITE;
                    default:            state <= ST_REFRESH;
                endcase
            end
        end else begin
            step <= step + 5'd1;
            if (last) begin
                state <= ST_IDLE;
            end
        end
    end

    // Held for the whole op
    always_ff @(posedge pclk) begin
        if (state == ST_IDLE && req_valid) begin
            cur_req <= req;
        end
    end

    assign seq_busy  = ~init_done | (state != ST_IDLE);
    assign rd_strobe = (state == ST_READ) && (step == 5'(RD_DATA));

    always_comb begin
        wr_beat = 2'd0;                                     // No write data
        if (state == ST_WRITE && step == 5'(WR_BEAT1)) begin
            wr_beat = 2'd1;
        end else if (state == ST_WRITE && step == 5'(WR_BEAT1 + 1)) begin
            wr_beat = 2'd2;
        end
    end

    // Column word is {A12 BL, A11, A10 auto precharge, A9..A0}
    always_comb begin
        slots = '{default: ddr3_pkg::SLOT_IDLE};
        if ((state == ST_READ || state == ST_WRITE) && step == '0) begin
            slots[0] = {ddr3_pkg::CMD_ACT, cur_req.bank, cur_req.row};
        end
        if (state == ST_READ && step == 5'(CMD_STEP)) begin
            slots[CMD_SLOT] = {ddr3_pkg::CMD_RD, cur_req.bank, 3'b101, cur_req.col};
        end
        if (state == ST_WRITE && step == 5'(CMD_STEP)) begin
            slots[CMD_SLOT] = {ddr3_pkg::CMD_WR, cur_req.bank, 3'b001, cur_req.col}; // BC4
        end
        if (state == ST_REFRESH && step == '0) begin
            slots[0].cmd = ddr3_pkg::CMD_REF;               // Banks already closed by AP
        end
    end

endmodule

// ==== source/ddr3_phase_packer.sv ====
//====================================================================
// Output stage: merges init and op command slots, builds the write
// lane patterns per beat and captures read data. All registered.
//====================================================================
module ddr3_phase_packer (
    input  logic                  pclk,
    input  logic                  rst_lock_n,
    input  ddr3_pkg::cmd_bundle_t init_slots,
    input  ddr3_pkg::cmd_bundle_t op_slots,
    input  logic [1:0]            wr_beat,
    input  ddr3_pkg::mem_req_t    cur_req,
    input  logic                  rd_strobe,
    input  logic                  seq_busy,
    input  logic [0:7][15:0]      rd_phases,
    output ddr3_pkg::cmd_bundle_t cmd_slots,
    output ddr3_pkg::wr_lanes_t   wr_lanes,
    output logic                  busy,
    output logic                  data_ready,
    output logic [15:0]           dout
);
    // All lanes tri-stated and masked
    localparam ddr3_pkg::wr_lanes_t LANES_IDLE = '{
        dq: '0, dq_oen: '1, dqs: '0, dqs_oen: '1, dm: '1
    };

    ddr3_pkg::cmd_bundle_t merged;
    ddr3_pkg::wr_lanes_t   lanes;

    // Sources never overlap, a busy slot wins over NOP
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[i] = (init_slots[i].cmd != ddr3_pkg::CMD_NOP) ? init_slots[i] : op_slots[i];
        end
    end

    // BC4 burst spans phase 7 and phases 0..2, dm picks the one word
    always_comb begin
        lanes = LANES_IDLE;
        case (wr_beat)
            2'd1: begin
                lanes.dqs     = 8'b1111_1110;
                lanes.dqs_oen = 4'b1110;
                lanes.dq_oen  = 4'b1110;
                lanes.dq[7]   = cur_req.din;
                lanes.dm[7]   = (cur_req.wib != 2'd0);
            end
            2'd2: begin
                lanes.dqs     = 8'b1010_0000;
                lanes.dqs_oen = 4'b0011;
                lanes.dq_oen  = 4'b0011;
                for (int k = 0; k < 3; k++) begin
                    lanes.dq[k] = cur_req.din;
                    lanes.dm[k] = (cur_req.wib != 2'(k + 1));
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            cmd_slots  <= '{default: ddr3_pkg::SLOT_IDLE};
            wr_lanes   <= LANES_IDLE;
            busy       <= 1'b1;                 // Busy through init
            data_ready <= 1'b0;
        end else begin
            cmd_slots  <= merged;
            wr_lanes   <= lanes;
            busy       <= seq_busy;
            data_ready <= rd_strobe;            // Single-cycle pulse
        end
    end

    always_ff @(posedge pclk) begin
        if (rd_strobe) begin
            dout <= rd_phases[0];               // DDR3-800 word lands in phase 0
        end
    end

endmodule

// ==== source/ddr3_cmd_top.sv ====
//====================================================================
// DDR3 command controller top. Connects request decode, init and op
// sequencers and the phase packer; timing defaults are DDR3-800.
//====================================================================
module ddr3_cmd_top #(
    parameter int ROW_WIDTH  = 13,
    parameter int COL_WIDTH  = 10,
    parameter int BANK_WIDTH = 3,
    parameter int RESET_WAIT = 20000,   // 200 us at 100 MHz
    parameter int CKE_WAIT   = 50020,   // 500 us plus tXPR
    parameter int ZQ_WAIT    = 514,     // tZQinit, 512 clocks plus margin
    parameter int CAS        = 6,
    parameter int CWL        = 5,
    parameter int MRD        = 8,
    parameter int RCD        = 6,
    parameter int RC         = 20,
    parameter int MOD        = 12
) (
    input  logic                                      pclk,
    input  logic                                      rst_lock_n,
    input  logic                                      rd,
    input  logic                                      wr,
    input  logic                                      refresh,
    input  logic [BANK_WIDTH+ROW_WIDTH+COL_WIDTH-1:0] addr,
    input  logic [15:0]                               din,
    input  logic [0:7][15:0]                          rd_phases,
    output ddr3_pkg::cmd_bundle_t                     cmd_slots,
    output ddr3_pkg::wr_lanes_t                       wr_lanes,
    output logic                                      ddr_reset_n,
    output logic                                      cke,
    output logic                                      busy,
    output logic                                      data_ready,
    output logic [15:0]                               dout
);
    ddr3_pkg::mem_req_t    req, cur_req;
    ddr3_pkg::cmd_bundle_t init_slots, op_slots;
    logic                  req_valid, seq_busy, init_done, rd_strobe;
    logic [1:0]            wr_beat;

    ddr3_request_decode #(
        .ROW_WIDTH(ROW_WIDTH), .COL_WIDTH(COL_WIDTH), .BANK_WIDTH(BANK_WIDTH)
    ) u_decode (
        .pclk, .rst_lock_n, .rd, .wr, .refresh, .addr, .din, .seq_busy,
        .req, .req_valid
    );

    ddr3_init_seq #(
        .RESET_WAIT(RESET_WAIT), .CKE_WAIT(CKE_WAIT), .ZQ_WAIT(ZQ_WAIT),
        .MRD(MRD), .MOD(MOD)
    ) u_init (
        .pclk, .rst_lock_n, .slots(init_slots), .ddr_reset_n, .cke, .init_done
    );

    ddr3_op_sequencer #(
        .RCD(RCD), .CAS(CAS), .CWL(CWL), .RC(RC)
    ) u_seq (
        .pclk, .rst_lock_n, .init_done, .req, .req_valid, .slots(op_slots),
        .wr_beat, .rd_strobe, .seq_busy, .cur_req
    );

    ddr3_phase_packer u_packer (
        .pclk, .rst_lock_n, .init_slots, .op_slots, .wr_beat, .cur_req, .rd_strobe,
        .seq_busy, .rd_phases, .cmd_slots, .wr_lanes, .busy, .data_ready, .dout
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
//====================================================================
// Free-running testbench clock, starts low, 50% duty
//====================================================================
module tb_clock_gen #(
    parameter int PERIOD = 10
) (
    output logic pclk
);
    initial begin
        pclk = 1'b0;
        forever begin
            #(PERIOD / 2) pclk = ~pclk;     // Half period per toggle
        end
    end

endmodule

// ==== testbench/tb_ddr3_cmd.sv ====
//====================================================================
// Testbench for the DDR3 command controller. Runs the power-up check,
// then replays requests from the input data file against expectations.
//====================================================================
module tb_ddr3_cmd;

    localparam int RESET_WAIT = 20;
    localparam int CKE_WAIT   = 20;
    localparam int ZQ_WAIT    = 4;
    localparam int MRD        = 8;      // DDR3-800 top defaults
    localparam int MOD        = 12;
    localparam int MAX_LINES  = 64;

    // RAS CAS WE
    localparam logic [2:0] C_MRS  = 3'b000;
    localparam logic [2:0] C_REF  = 3'b001;
    localparam logic [2:0] C_ACT  = 3'b011;
    localparam logic [2:0] C_WR   = 3'b100;
    localparam logic [2:0] C_RD   = 3'b101;
    localparam logic [2:0] C_ZQCL = 3'b110;
    localparam logic [2:0] C_NOP  = 3'b111;

    // Op codes of the data file
    localparam logic [7:0] OP_RD    = 8'h00;
    localparam logic [7:0] OP_WR    = 8'h01;
    localparam logic [7:0] OP_REF   = 8'h02;
    localparam logic [7:0] OP_PULSE = 8'h03;    // Refresh then rd pulse while busy
    localparam logic [7:0] OP_BOTH  = 8'h04;    // rd and wr together
    localparam logic [7:0] OP_IDLE  = 8'hfe;    // Nothing issued

    logic                  pclk;
    logic                  rst_lock_n;
    logic                  rd;
    logic                  wr;
    logic                  refresh;
    logic [25:0]           addr;
    logic [15:0]           din;
    logic [0:7][15:0]      rd_phases;
    ddr3_pkg::cmd_bundle_t cmd_slots;
    ddr3_pkg::wr_lanes_t   wr_lanes;
    logic                  ddr_reset_n;
    logic                  cke;
    logic                  busy;
    logic                  data_ready;
    logic [15:0]           dout;

    logic [31:0] vec_mem [0:4*MAX_LINES-1];     // Four words per line
    int          num_lines;
    int          cycle_count    = 0;
    int          cycle_limit    = 0;
    int          check_count    = 0;
    int          mismatch_count = 0;
    int          fault_count    = 0;

    tb_clock_gen #(.PERIOD(10)) u_clk (.pclk(pclk));

    ddr3_cmd_top #(
        .RESET_WAIT(RESET_WAIT), .CKE_WAIT(CKE_WAIT), .ZQ_WAIT(ZQ_WAIT)
    ) uut (
        .pclk, .rst_lock_n, .rd, .wr, .refresh, .addr, .din, .rd_phases,
        .cmd_slots, .wr_lanes, .ddr_reset_n, .cke, .busy, .data_ready, .dout
    );

    task automatic report_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, fault_count);
    endtask

    // Run limit is set once the data file is read
    always @(posedge pclk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout, run did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("tests failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [151:0] got,
                                 input logic [151:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("MISMATCH time=%0t %s expected=%0h got=%0h", $time, name, exp, got);
        end
    endtask

    task automatic require(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            fault_count++;
            $display("ERROR time=%0t %s", $time, what);
        end
    endtask

    // Slots t cycles after the ACT or REF step
    function automatic ddr3_pkg::cmd_bundle_t expect_slots(input logic [7:0] op,
                                                           input logic [25:0] a, input int t);
        ddr3_pkg::cmd_bundle_t s;
        for (int i = 0; i < 4; i++) begin
            s[i] = {C_NOP, 16'h0000};
        end
        if ((op == OP_RD || op == OP_BOTH || op == OP_WR) && t == 0) begin
            s[0] = {C_ACT, a[25:23], a[22:10]};
        end
        if ((op == OP_RD || op == OP_BOTH) && t == 1) begin
            s[2] = {C_RD, a[25:23], 3'b101, a[9:0]};    // A12 and A10 set
        end
        if (op == OP_WR && t == 1) begin
            s[2] = {C_WR, a[25:23], 3'b001, a[9:0]};    // BC4 with auto precharge
        end
        if ((op == OP_REF || op == OP_PULSE) && t == 0) begin
            s[0] = {C_REF, 16'h0000};
        end
        return s;
    endfunction

    function automatic ddr3_pkg::wr_lanes_t expect_lanes(input logic [7:0] op,
                                                         input logic [25:0] a,
                                                         input logic [15:0] d, input int t);
        ddr3_pkg::wr_lanes_t l;
        l.dq      = '0;
        l.dq_oen  = 4'b1111;    // Idle lanes off and masked
        l.dqs     = 8'h00;
        l.dqs_oen = 4'b1111;
        l.dm      = 8'hff;
        if (op == OP_WR && t == 2) begin
            l.dq[7]   = d;
            l.dq_oen  = 4'b1110;
            l.dqs     = 8'b1111_1110;
            l.dqs_oen = 4'b1110;
            l.dm[7]   = (a[1:0] != 2'd0);
        end else if (op == OP_WR && t == 3) begin
            l.dq_oen  = 4'b0011;
            l.dqs     = 8'b1010_0000;
            l.dqs_oen = 4'b0011;
            for (int k = 0; k < 3; k++) begin
                l.dq[k] = d;
                l.dm[k] = (a[1:0] != 2'(k + 1));   // Only the addressed word
            end
        end
        return l;
    endfunction

    // Releases reset and follows power-up until busy falls
    task automatic run_init();
        logic [2:0]  exp_cmd  [0:4];
        logic [15:0] exp_ba   [0:4];
        int          exp_step [0:4];
        int          count;
        int          rst_at;
        int          cke_at;
        int          zq_at;
        int          seen;
        exp_cmd  = '{C_MRS, C_MRS, C_MRS, C_MRS, C_ZQCL};
        exp_ba   = '{16'h4200, 16'h6000, 16'h2000, 16'h0521, 16'h0400};
        exp_step = '{0, MRD/4, MRD/2, MRD*3/4, MRD*3/4 + MOD/4 + 1};
        count  = 0;
        rst_at = -1;
        cke_at = -1;
        zq_at  = -1;
        seen   = 0;
        rst_lock_n = 1'b1;
        while (busy !== 1'b0) begin
            @(negedge pclk);
            count++;
            if (ddr_reset_n === 1'b1 && rst_at < 0) begin
                rst_at = count;
            end
            if (cke === 1'b1 && cke_at < 0) begin
                cke_at = count;
                require(rst_at >= 0, "cke rose before ddr_reset_n");
            end
            for (int i = 0; i < 4; i++) begin
                if (cmd_slots[i].cmd !== C_NOP) begin
                    if (i != 0 || seen >= 5) begin
                        require(1'b0, $sformatf("unexpected init command in slot %0d", i));
                    end else begin
                        compare_value("cmd_slots[0].cmd", cmd_slots[0].cmd, exp_cmd[seen]);
                        compare_value("cmd_slots[0] bank/addr",
                                      {cmd_slots[0].bank, cmd_slots[0].addr}, exp_ba[seen]);
                        compare_value("init config step", count - cke_at - 1, exp_step[seen]);
                        if (seen == 4) begin
                            zq_at = count;
                        end
                        seen++;
                    end
                end
            end
        end
        require(seen == 5, "init did not issue all five commands");
        compare_value("ddr_reset_n rise cycle", rst_at, RESET_WAIT);
        compare_value("cke rise delay", cke_at - rst_at, CKE_WAIT);
        compare_value("busy fall after ZQCL", count - zq_at, ZQ_WAIT + 1);
    endtask

    // One request line checked cycle by cycle from the issuing edge
    task automatic run_op(input logic [7:0] op, input logic [25:0] a,
                          input logic [15:0] d, input logic [15:0] ph);
        ddr3_pkg::cmd_bundle_t exp_s;
        int                    busy_len;
        int                    t;
        logic                  is_read;
        is_read  = (op == OP_RD || op == OP_BOTH);
        busy_len = is_read ? 9 : 5;
        while (busy !== 1'b0) begin
            @(negedge pclk);
        end
        addr    = a;
        din     = d;
        rd      = is_read;
        wr      = (op == OP_WR || op == OP_BOTH);
        refresh = (op == OP_REF || op == OP_PULSE);
        for (int s = 1; s <= busy_len + 6; s++) begin
            @(negedge pclk);
            t       = s - 3;                        // ACT two cycles after accept
            rd      = (op == OP_PULSE && t == 3);   // Sampled on the last busy step
            wr      = 1'b0;
            refresh = 1'b0;
            rd_phases[0] = (t == 7) ? ph : ~ph;     // Only the capture cycle is valid
            exp_s = expect_slots(op, a, t);
            for (int i = 0; i < 4; i++) begin
                compare_value($sformatf("cmd_slots[%0d]", i), cmd_slots[i], exp_s[i]);
            end
            compare_value("wr_lanes", wr_lanes, expect_lanes(op, a, d, t));
            compare_value("busy", busy, t >= 0 && t < busy_len);
            compare_value("data_ready", data_ready, is_read && t == 8);
            if (is_read && t == 8) begin
                compare_value("dout", dout, ph);
            end
        end
    endtask

    initial begin
        rst_lock_n = 1'b0;
        rd         = 1'b0;
        wr         = 1'b0;
        refresh    = 1'b0;
        addr       = '0;
        din        = '0;
        for (int k = 0; k < 8; k++) begin
            rd_phases[k] = 16'hc0d0 + 16'(k);
        end
        $readmemh("testbench/ddr3_cmd_input.txt", vec_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && !$isunknown(vec_mem[4*num_lines])
               && vec_mem[4*num_lines] != 32'h0000_00ff) begin
            num_lines++;
        end
        cycle_limit = 200 + 20*num_lines;
        repeat (8) @(posedge pclk);
        @(negedge pclk);
        // Reset values while still in reset
        compare_value("busy", busy, 1'b1);
        compare_value("data_ready", data_ready, 1'b0);
        compare_value("cke", cke, 1'b0);
        compare_value("ddr_reset_n", ddr_reset_n, 1'b0);
        compare_value("cmd_slots", cmd_slots, expect_slots(OP_IDLE, '0, -1));
        compare_value("wr_lanes", wr_lanes, expect_lanes(OP_IDLE, '0, '0, -1));
        run_init();
        for (int n = 0; n < num_lines; n++) begin
            run_op(vec_mem[4*n][7:0], vec_mem[4*n+1][25:0], vec_mem[4*n+2][15:0],
                   vec_mem[4*n+3][15:0]);
        end
        report_counts();
        if (mismatch_count + fault_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/ddr3_pkg.sv
source/ddr3_request_decode.sv
source/ddr3_init_seq.sv
source/ddr3_op_sequencer.sv
source/ddr3_phase_packer.sv
source/ddr3_cmd_top.sv
testbench/tb_clock_gen.sv
testbench/tb_ddr3_cmd.sv

// ==== testbench/ddr3_cmd_input.txt ====
// Columns: op addr din rd_phase0, hex. addr is {bank[2:0], row[12:0], col[9:0]}
// op 0 read, 1 write, 2 refresh, 3 refresh with rd pulse while busy, 4 rd+wr, ff ends
0 0000000 0000 1234
1 0000000 a5a5 0000
1 0000401 5a5a 0000
1 1002402 0f0f 0000
1 3ffffff f0f0 0000
0 3ffffff 0000 ffff
0 2a55678 0000 8001
2 0000000 0000 0000
0 0801c03 0000 4321
3 1234567 0000 0000
1 00c0cc1 dead 0000
4 1555555 beef 7e57
2 0000000 0000 0000
0 0ff3ff2 0000 0f0f
3 3000000 0000 0000
1 2aaaaa2 0001 0000
4 0400003 ffff 0000
0 155aa55 0000 aaaa
ff 0 0 0
